// ==== obj_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object engine configuration
// Object table layout, sprite geometry and graphics ROM addressing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package obj_cfg_pkg;

    // Table geometry
    localparam int obj_count = 24;
    localparam int obj_bytes = 4;
    localparam int ram_aw    = 7;
    // Sprites are square
    localparam int obj_size  = 16;

    typedef logic [ram_aw-1:0] obj_addr_t;
    typedef logic [7:0]        obj_byte_t;
    typedef logic [7:0]        code_t;
    // Bit 7 vflip, bit 6 hflip, bits 3..0 palette
    typedef logic [7:0]        attr_t;
    typedef logic [3:0]        pal_t;
    typedef logic [3:0]        vsub_t;
    // {code, row, half}
    typedef logic [12:0]       rom_addr_t;
    // Eight 4-bit pixels, leftmost in bits 31..28
    typedef logic [31:0]       rom_word_t;
    // {palette, pixel index}
    typedef logic [7:0]        prom_addr_t;

endpackage

`default_nettype wire

// ==== obj_video_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object engine video types
// Raster positions and pixel colour widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package obj_video_pkg;

    // Visible columns held in one line buffer
    localparam int buf_len = 256;

    typedef logic [7:0] vpos_t;
    typedef logic [8:0] hpos_t;
    typedef logic [7:0] xpos_t;
    typedef logic [3:0] pix_idx_t;
    // Zero is transparent / background
    typedef logic [3:0] colour_t;

endpackage

`default_nettype wire

// ==== obj_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object table RAM
// 128-byte dual-port memory. CPU port reads and writes, scanner port
// only reads. Both reads are registered.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module obj_ram (
    input  logic                   clk,
    // CPU side
    input  obj_cfg_pkg::obj_addr_t cpu_addr,
    input  obj_cfg_pkg::obj_byte_t cpu_dout,
    input  logic                   cpu_we,
    output obj_cfg_pkg::obj_byte_t cpu_q,
    // Scanner side
    input  obj_cfg_pkg::obj_addr_t scan_addr,
    output obj_cfg_pkg::obj_byte_t scan_data
);

    obj_cfg_pkg::obj_byte_t mem [2**obj_cfg_pkg::ram_aw];

    // CPU port returns the old value on a write
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_dout;
        end
        cpu_q <= mem[cpu_addr];
    end

    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

endmodule

`default_nettype wire

// ==== obj_scan.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object table scanner
// Walks all table entries once per line, four bytes each, and passes
// the objects that cover vrender to the draw unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module obj_scan (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hinit,
    input  obj_video_pkg::vpos_t   vrender,
    // Table read port, one cycle latency
    output obj_cfg_pkg::obj_addr_t scan_addr,
    input  obj_cfg_pkg::obj_byte_t scan_data,
    // Draw unit handoff
    input  logic                   busy,
    output logic                   draw,
    output obj_cfg_pkg::code_t     code,
    output obj_video_pkg::xpos_t   xpos,
    output obj_cfg_pkg::pal_t      pal,
    output logic                   hflip,
    output logic                   vflip,
    output obj_cfg_pkg::vsub_t     vsub
);

    typedef enum logic [2:0] {
        idle,
        read_y,
        read_code,
        read_x,
        read_attr,
        issue
    } scan_state_t;

    scan_state_t            state;
    obj_video_pkg::vpos_t   ydiff;
    obj_cfg_pkg::code_t     code_q;
    obj_video_pkg::xpos_t   x_q;
    obj_cfg_pkg::attr_t     attr;
    logic                   last_entry;

    // Attribute byte is on the bus while in issue
    assign attr       = scan_data;
    assign last_entry = scan_addr == obj_cfg_pkg::obj_addr_t'(
                        obj_cfg_pkg::obj_count * obj_cfg_pkg::obj_bytes - 1);

    // The address runs one state ahead of the data
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= idle;
            scan_addr <= '0;
            draw      <= 1'b0;
        end else begin
            draw <= 1'b0;
            if (hinit) begin
                state     <= read_y;
                scan_addr <= '0;
            end else begin
                case (state)
                    read_y:    begin
                        scan_addr <= scan_addr + 1'b1;
                        state     <= read_code;
                    end
                    read_code: begin
                        scan_addr <= scan_addr + 1'b1;
                        state     <= read_x;
                    end
                    read_x:    begin
                        scan_addr <= scan_addr + 1'b1;
                        state     <= read_attr;
                    end
                    read_attr: state <= issue;
                    issue:     if (!busy) begin
                        // Only objects covering this line get drawn
                        draw      <= ydiff < obj_cfg_pkg::obj_size;
                        scan_addr <= scan_addr + 1'b1;
                        state     <= last_entry ? idle : read_y;
                    end
                    default:   state <= idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            // Y is stored inverted
            read_code: ydiff  <= vrender - obj_video_pkg::vpos_t'(~scan_data);
            read_x:    code_q <= scan_data;
            read_attr: x_q    <= scan_data;
            issue:     if (!busy) begin
                code  <= code_q;
                xpos  <= x_q;
                pal   <= obj_cfg_pkg::pal_t'(attr[3:0]);
                hflip <= attr[6];
                vflip <= attr[7];
                vsub  <= obj_cfg_pkg::vsub_t'(ydiff[3:0]);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== obj_draw.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object draw unit
// Fetches one sprite row as two ROM halves, applies the flips, maps
// pixels through the colour PROM and writes them to the line buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module obj_draw (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    draw,
    output logic                    busy,
    input  obj_cfg_pkg::code_t      code,
    input  obj_video_pkg::xpos_t    xpos,
    input  obj_cfg_pkg::pal_t       pal,
    input  logic                    hflip,
    input  logic                    vflip,
    input  obj_cfg_pkg::vsub_t      vsub,
    // Colour PROM load
    input  logic                    prog_en,
    input  obj_cfg_pkg::prom_addr_t prog_addr,
    input  obj_video_pkg::colour_t  prog_data,
    // Graphics ROM
    output logic                    rom_cs,
    output obj_cfg_pkg::rom_addr_t  rom_addr,
    input  obj_cfg_pkg::rom_word_t  rom_data,
    input  logic                    rom_ok,
    // Line buffer write
    output logic                    buf_we,
    output obj_video_pkg::xpos_t    buf_addr,
    output obj_video_pkg::colour_t  buf_data
);

    localparam int half_w = obj_cfg_pkg::obj_size / 2;

    obj_video_pkg::colour_t  prom [256];
    obj_video_pkg::xpos_t    obj_xpos;
    obj_cfg_pkg::pal_t       obj_pal;
    logic                    obj_hflip;
    obj_cfg_pkg::vsub_t      row;
    logic                    second, need2, rom_ack;
    logic                    pend_vld, pend_half2;
    obj_cfg_pkg::rom_word_t  pend_word;
    obj_cfg_pkg::rom_word_t  sh_word;
    logic [3:0]              sh_cnt;
    logic [8:0]              sh_col;
    logic                    sh_half2, out_last;
    obj_video_pkg::pix_idx_t pix;

    // Swap the eight pixels of a word end for end
    function automatic obj_cfg_pkg::rom_word_t nib_rev(input obj_cfg_pkg::rom_word_t w);
        obj_cfg_pkg::rom_word_t r;
        for (int i = 0; i < 8; i++) begin
            r[i*4 +: 4] = w[(7-i)*4 +: 4];
        end
        return r;
    endfunction

    assign row     = vflip ? obj_cfg_pkg::vsub_t'(obj_cfg_pkg::obj_size - 1) - vsub : vsub;
    assign rom_ack = rom_cs && rom_ok;
    assign pix     = sh_word[31:28];

    always_ff @(posedge clk) begin
        if (prog_en) begin
            prom[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            rom_cs   <= 1'b0;
            second   <= 1'b0;
            need2    <= 1'b0;
            pend_vld <= 1'b0;
            sh_cnt   <= '0;
            buf_we   <= 1'b0;
            out_last <= 1'b0;
        end else begin
            if (draw) begin
                busy   <= 1'b1;
                rom_cs <= 1'b1;
                second <= 1'b0;
                need2  <= 1'b0;
            end else if (rom_ack) begin
                // cs drops for a cycle between the two halves
                rom_cs <= 1'b0;
                need2  <= !second;
            end else if (need2) begin
                rom_cs <= 1'b1;
                second <= 1'b1;
                need2  <= 1'b0;
            end else if (out_last) begin
                busy <= 1'b0;
            end
            if (rom_ack) begin
                pend_vld <= 1'b1;
            end else if (sh_cnt == 0) begin
                pend_vld <= 1'b0;
            end
            if (sh_cnt != 0) begin
                sh_cnt <= sh_cnt - 1'b1;
            end else if (pend_vld) begin
                sh_cnt <= 4'(half_w);
            end
            // Transparent pixels and columns past 255 are dropped
            buf_we   <= sh_cnt != 0 && pix != 0 && !sh_col[8];
            out_last <= sh_cnt == 1 && sh_half2;
        end
    end

    always_ff @(posedge clk) begin
        if (draw) begin
            obj_xpos  <= xpos;
            obj_pal   <= pal;
            obj_hflip <= hflip;
            // Flipped sprites start with the right half
            rom_addr  <= {code, row, hflip};
        end else if (need2) begin
            rom_addr[0] <= ~rom_addr[0];
        end
        if (rom_ack) begin
            pend_word  <= rom_data;
            pend_half2 <= second;
        end
        if (sh_cnt != 0) begin
            sh_word <= sh_word << 4;
            sh_col  <= sh_col + 1'b1;
        end else if (pend_vld) begin
            sh_word  <= obj_hflip ? nib_rev(pend_word) : pend_word;
            sh_col   <= {1'b0, obj_xpos} + (pend_half2 ? 9'(half_w) : 9'd0);
            sh_half2 <= pend_half2;
        end
        buf_addr <= sh_col[7:0];
        buf_data <= prom[obj_cfg_pkg::prom_addr_t'({obj_pal, pix})];
    end

endmodule

`default_nettype wire

// ==== obj_linebuf.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ping-pong line buffer
// One bank takes the sprites of the next line, the other is shown at
// hdump and cleared behind the beam. Banks swap on hinit.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module obj_linebuf (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hinit,
    input  logic                   pxl_cen,
    input  logic                   lhbl,
    input  obj_video_pkg::hpos_t   hdump,
    input  logic                   buf_we,
    input  obj_video_pkg::xpos_t   buf_addr,
    input  obj_video_pkg::colour_t buf_data,
    output obj_video_pkg::colour_t pxl
);

    // Bank being drawn while the other one is on screen
    logic                   bank;
    logic                   vis;
    obj_video_pkg::colour_t rd_bank [2];

    assign vis = hdump < obj_video_pkg::buf_len;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        obj_video_pkg::colour_t mem [obj_video_pkg::buf_len] = '{default: '0};
        logic                   draw_side;

        assign draw_side  = bank == 1'(b);
        assign rd_bank[b] = mem[hdump[7:0]];

        always_ff @(posedge clk) begin
            if (draw_side) begin
                // First opaque write wins, so lower table entries stay on top
                if (buf_we && mem[buf_addr] == '0) begin
                    mem[buf_addr] <= buf_data;
                end
            end else if (pxl_cen && vis) begin
                mem[hdump[7:0]] <= '0;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
            pxl  <= '0;
        end else begin
            if (hinit) begin
                bank <= ~bank;
            end
            if (pxl_cen) begin
                pxl <= (lhbl && vis) ? rd_bank[~bank] : '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== obj_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite engine top level
// Object table RAM, line scanner, draw unit and line buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module obj_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hinit,
    input  logic                    lhbl,
    input  logic                    pxl_cen,
    input  obj_video_pkg::vpos_t    vrender,
    input  obj_video_pkg::hpos_t    hdump,
    // CPU bus
    input  obj_cfg_pkg::obj_addr_t  cpu_addr,
    input  obj_cfg_pkg::obj_byte_t  cpu_dout,
    input  logic                    obj_cs,
    input  logic                    cpu_rnw,
    output obj_cfg_pkg::obj_byte_t  obj_dout,
    // Colour PROM load
    input  logic                    prog_en,
    input  obj_cfg_pkg::prom_addr_t prog_addr,
    input  obj_video_pkg::colour_t  prog_data,
    // Graphics ROM
    output logic                    rom_cs,
    output obj_cfg_pkg::rom_addr_t  rom_addr,
    input  obj_cfg_pkg::rom_word_t  rom_data,
    input  logic                    rom_ok,
    output obj_video_pkg::colour_t  pxl
);

    logic                   obj_we;
    obj_cfg_pkg::obj_addr_t scan_addr;
    obj_cfg_pkg::obj_byte_t scan_data;
    logic                   draw, busy, hflip, vflip;
    obj_cfg_pkg::code_t     code;
    obj_video_pkg::xpos_t   xpos;
    obj_cfg_pkg::pal_t      pal;
    obj_cfg_pkg::vsub_t     vsub;
    logic                   buf_we;
    obj_video_pkg::xpos_t   buf_addr;
    obj_video_pkg::colour_t buf_data;

    assign obj_we = obj_cs & ~cpu_rnw;

    obj_ram u_ram (
        .clk       ( clk       ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_we    ( obj_we    ),
        .cpu_q     ( obj_dout  ),
        .scan_addr ( scan_addr ),
        .scan_data ( scan_data )
    );

    obj_scan u_scan (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .hinit     ( hinit     ),
        .vrender   ( vrender   ),
        .scan_addr ( scan_addr ),
        .scan_data ( scan_data ),
        .busy      ( busy      ),
        .draw      ( draw      ),
        .code      ( code      ),
        .xpos      ( xpos      ),
        .pal       ( pal       ),
        .hflip     ( hflip     ),
        .vflip     ( vflip     ),
        .vsub      ( vsub      )
    );

    obj_draw u_draw (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .draw      ( draw      ),
        .busy      ( busy      ),
        .code      ( code      ),
        .xpos      ( xpos      ),
        .pal       ( pal       ),
        .hflip     ( hflip     ),
        .vflip     ( vflip     ),
        .vsub      ( vsub      ),
        .prog_en   ( prog_en   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .buf_we    ( buf_we    ),
        .buf_addr  ( buf_addr  ),
        .buf_data  ( buf_data  )
    );

    obj_linebuf u_buf (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .hinit     ( hinit     ),
        .pxl_cen   ( pxl_cen   ),
        .lhbl      ( lhbl      ),
        .hdump     ( hdump     ),
        .buf_we    ( buf_we    ),
        .buf_addr  ( buf_addr  ),
        .buf_data  ( buf_data  ),
        .pxl       ( pxl       )
    );

endmodule

`default_nettype wire

// ==== tb_obj_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite engine testbench
// Drives video timing, CPU table writes and the colour PROM load, models
// the graphics ROM with random latency and checks every output pixel
// against a reference model of the object table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_obj_engine;

    localparam int line_clks   = 768;
    localparam int table_len   = obj_cfg_pkg::obj_count * obj_cfg_pkg::obj_bytes;
    // Table load window starts once the scan of the line is over
    localparam int load_start  = 640;
    localparam int total_lines = 5 * 19 + 1;
    localparam int cycle_limit = total_lines * line_clks + 3000;

    logic                    clk = 1'b0;
    logic                    rst, hinit, lhbl, pxl_cen;
    obj_video_pkg::vpos_t    vrender;
    obj_video_pkg::hpos_t    hdump;
    obj_cfg_pkg::obj_addr_t  cpu_addr;
    obj_cfg_pkg::obj_byte_t  cpu_dout, obj_dout;
    logic                    obj_cs, cpu_rnw, prog_en;
    obj_cfg_pkg::prom_addr_t prog_addr;
    obj_video_pkg::colour_t  prog_data, pxl;
    logic                    rom_cs, rom_ok;
    obj_cfg_pkg::rom_addr_t  rom_addr;
    obj_cfg_pkg::rom_word_t  rom_data;

    // Table copies as written by the CPU, as scanned and as on screen
    obj_cfg_pkg::obj_byte_t  tb_tbl   [table_len];
    obj_cfg_pkg::obj_byte_t  new_tbl  [table_len];
    obj_cfg_pkg::obj_byte_t  scan_tbl [table_len];
    obj_cfg_pkg::obj_byte_t  disp_tbl [table_len];
    obj_video_pkg::vpos_t    scan_v, disp_v;

    logic [31:0]             lfsr = 32'h9224_d599;
    int                      rom_wait = -1;
    int                      err_count = 0;
    int                      chk_count = 0;
    int                      tests_ok = 0;
    int                      tests_bad = 0;
    int                      cycles = 0;
    logic                    chk_pend = 1'b0;
    obj_video_pkg::colour_t  chk_exp;
    obj_video_pkg::vpos_t    chk_v;
    obj_video_pkg::hpos_t    chk_h;

    obj_engine u_obj_engine (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .hinit     ( hinit     ),
        .lhbl      ( lhbl      ),
        .pxl_cen   ( pxl_cen   ),
        .vrender   ( vrender   ),
        .hdump     ( hdump     ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .obj_cs    ( obj_cs    ),
        .cpu_rnw   ( cpu_rnw   ),
        .obj_dout  ( obj_dout  ),
        .prog_en   ( prog_en   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .pxl       ( pxl       )
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // Graphics ROM contents
    function automatic obj_cfg_pkg::rom_word_t rom_hash(input obj_cfg_pkg::rom_addr_t a);
        return (32'(a) * 32'h9e37_79b1) ^ {a[5:0], a, a};
    endfunction

    // Expected pixel at column hd of the line rendered for v
    function automatic obj_video_pkg::colour_t ref_colour(input obj_video_pkg::vpos_t v,
            input obj_video_pkg::hpos_t hd, input logic lb);
        obj_video_pkg::vpos_t    ydiff;
        logic [8:0]              col;
        logic [3:0]              sx, sy, idx;
        obj_cfg_pkg::attr_t      attr;
        obj_cfg_pkg::rom_word_t  word;
        obj_video_pkg::colour_t  c;
        if (!lb || hd >= 9'd256) begin
            return '0;
        end
        for (int i = 0; i < obj_cfg_pkg::obj_count; i++) begin
            ydiff = v - ~disp_tbl[4*i];
            col   = hd - {1'b0, disp_tbl[4*i+2]};
            attr  = disp_tbl[4*i+3];
            if (ydiff < 8'd16 && col < 9'd16) begin
                sy   = attr[7] ? 4'd15 - ydiff[3:0] : ydiff[3:0];
                sx   = attr[6] ? 4'd15 - col[3:0] : col[3:0];
                word = rom_hash({disp_tbl[4*i+1], sy, sx[3]});
                idx  = word[31 - 4*sx[2:0] -: 4];
                c    = (idx == 4'd0) ? 4'd0 : idx ^ attr[3:0];
                // A zero colour leaves the sprite behind visible
                if (c != 4'd0) begin
                    return c;
                end
            end
        end
        return '0;
    endfunction

    // ROM answers 1 to 4 cycles after cs rises
    always @(posedge clk) begin
        #10;
        if (rom_ok) begin
            rom_ok   = 1'b0;
            rom_wait = -1;
        end else if (rom_cs) begin
            if (rom_wait < 0) begin
                rom_wait = int'(rand_bits(2));
            end
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_hash(rom_addr);
            end else begin
                rom_wait--;
            end
        end
    end

    // Pixel checker reads pxl of the previous cen edge, which is stable here
    always @(posedge clk) begin
        if (chk_pend) begin
            chk_count++;
            assert (pxl === chk_exp) else begin
                $display("[ERROR] %0t ns: pxl of line %0d column %0d is %0h, expected %0h",
                         $time, chk_v, chk_h, pxl, chk_exp);
                err_count++;
            end
        end
        chk_pend = pxl_cen;
        if (pxl_cen) begin
            chk_exp = ref_colour(disp_v, hdump, lhbl);
            chk_v   = disp_v;
            chk_h   = hdump;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic close_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
            tests_bad++;
        end
    endtask

    task automatic clear_table();
        for (int i = 0; i < table_len; i++) begin
            // Y of 0xf0 never covers the tested lines
            new_tbl[i] = (i % 4 == 0) ? 8'h0f : 8'h00;
        end
    endtask

    task automatic set_entry(input int i, input int y, input int code, input int x,
            input obj_cfg_pkg::attr_t attr);
        new_tbl[4*i]   = ~8'(y);
        new_tbl[4*i+1] = 8'(code);
        new_tbl[4*i+2] = 8'(x);
        new_tbl[4*i+3] = attr;
    endtask

    // One video line that optionally loads new_tbl through the CPU port
    task automatic run_line(input obj_video_pkg::vpos_t v, input logic load);
        int idx;
        for (int c = 0; c < line_clks; c++) begin
            @(posedge clk);
            #10;
            hinit   = c == 0;
            pxl_cen = (c % 2) == 1;
            hdump   = obj_video_pkg::hpos_t'(c / 2);
            lhbl    = hdump >= 9'd8 && hdump < 9'd264;
            if (c == 0) begin
                vrender  = v;
                disp_tbl = scan_tbl;
                disp_v   = scan_v;
                scan_tbl = tb_tbl;
                scan_v   = v;
            end
            idx = c - load_start;
            if (load && idx >= 0 && idx < table_len) begin
                obj_cs      = 1'b1;
                cpu_rnw     = 1'b0;
                cpu_addr    = obj_cfg_pkg::obj_addr_t'(idx);
                cpu_dout    = new_tbl[idx];
                tb_tbl[idx] = new_tbl[idx];
            end else begin
                obj_cs  = 1'b0;
                cpu_rnw = 1'b1;
            end
        end
    endtask

    task automatic run_test(input string name, input int y0);
        int errs_before;
        errs_before = err_count;
        run_line(8'(y0 - 2), 1'b1);
        for (int n = -1; n <= 16; n++) begin
            run_line(8'(y0 + n), 1'b0);
        end
        close_test(name, errs_before);
    endtask

    task automatic check_cpu_port();
        int errs_before;
        errs_before = err_count;
        for (int i = 0; i < table_len; i++) begin
            @(posedge clk);
            #10;
            obj_cs    = 1'b1;
            cpu_rnw   = 1'b0;
            cpu_addr  = obj_cfg_pkg::obj_addr_t'(i);
            cpu_dout  = obj_cfg_pkg::obj_byte_t'(rand_bits(8));
            tb_tbl[i] = cpu_dout;
        end
        for (int i = 0; i <= table_len; i++) begin
            @(posedge clk);
            #10;
            cpu_rnw = 1'b1;
            if (i > 0) begin
                assert (obj_dout === tb_tbl[i-1]) else begin
                    $display("[ERROR] %0t ns: obj_dout at address %0d is %0h, expected %0h",
                             $time, i - 1, obj_dout, tb_tbl[i-1]);
                    err_count++;
                end
            end
            if (i < table_len) begin
                cpu_addr = obj_cfg_pkg::obj_addr_t'(i);
            end
        end
        obj_cs = 1'b0;
        close_test("cpu table write and read back", errs_before);
    endtask

    initial begin
        rst = 1'b1;
        hinit = 1'b0;
        lhbl = 1'b0;
        pxl_cen = 1'b0;
        vrender = '0;
        hdump = '0;
        cpu_addr = '0;
        cpu_dout = '0;
        obj_cs = 1'b0;
        cpu_rnw = 1'b1;
        prog_en = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        rom_ok = 1'b0;
        rom_data = '0;
        scan_v = '0;
        disp_v = '0;
        clear_table();
        scan_tbl = new_tbl;
        disp_tbl = new_tbl;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        assert (rom_cs === 1'b0 && pxl === '0) else begin
            $display("[ERROR] %0t ns: rom_cs or pxl not low after reset", $time);
            err_count++;
        end
        // Colour is index xor palette and index zero stays transparent
        for (int i = 0; i < 256; i++) begin
            prog_en   = 1'b1;
            prog_addr = obj_cfg_pkg::prom_addr_t'(i);
            prog_data = (i % 16 == 0) ? 4'd0 : 4'(i % 16) ^ 4'(i / 16);
            @(posedge clk);
            #10;
        end
        prog_en = 1'b0;
        check_cpu_port();

        clear_table();
        set_entry(0, 40, 8'h12, 60, 8'h03);
        run_test("single sprite", 40);

        clear_table();
        set_entry(0, 70, 8'h21, 20, 8'h45);
        set_entry(1, 70, 8'h21, 60, 8'h86);
        set_entry(2, 70, 8'h21, 100, 8'hc7);
        set_entry(3, 70, 8'h21, 140, 8'h07);
        run_test("horizontal and vertical flips", 70);

        clear_table();
        set_entry(0, 100, 8'h33, 120, 8'h01);
        set_entry(1, 104, 8'h34, 126, 8'h02);
        set_entry(2, 97, 8'h35, 124, 8'h49);
        run_test("overlap priority", 100);

        clear_table();
        set_entry(0, 130, 8'h40, 250, 8'h04);
        set_entry(1, 130, 8'h41, 2, 8'h05);
        set_entry(2, 131, 8'h42, 244, 8'h4a);
        run_test("right edge clip and blanking", 130);

        clear_table();
        for (int i = 0; i < obj_cfg_pkg::obj_count; i++) begin
            set_entry(i, 160 + i % 4, i * 7 + 3, i * 10, {i[1:0], 2'b00, i[3:0]});
        end
        run_test("full table", 160);

        // Shows the last rendered line of the previous test
        run_line(8'd200, 1'b0);
        repeat (2) @(posedge clk);
        $display("summary: %0d tests ok, %0d failed, %0d pixel checks, %0d errors",
                 tests_ok, tests_bad, chk_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
obj_cfg_pkg.sv
obj_video_pkg.sv
obj_ram.sv
obj_scan.sv
obj_draw.sv
obj_linebuf.sv
obj_engine.sv
tb_obj_engine.sv
